//--- uart_rx_pkg.sv
//==============================
// shared types and default widths for the uart receiver
// frame states are one-hot and parity codes match the register map
// widths here are defaults only, the top level may override them
//==============================

package uart_rx_pkg;

	//==============================
	// frame states
	//==============================

	// one-hot, five bits
	typedef enum logic [4:0]
	{
		RX_IDLE   = 5'b00001,
		RX_START  = 5'b00010,
		RX_DATA   = 5'b00100,
		RX_PARITY = 5'b01000,
		RX_STOP   = 5'b10000
	} rx_state_e;

	//==============================
	// parity modes
	//==============================

	// even and odd are computed from the word
	// space and mark are fixed levels
	typedef enum logic [1:0]
	{
		PAR_EVEN  = 2'd0,
		PAR_ODD   = 2'd1,
		PAR_SPACE = 2'd2,
		PAR_MARK  = 2'd3
	} parity_mode_e;

	// divisor and oversampling setting widths
	localparam int DEF_CLKDIV_W   = 12;
	localparam int DEF_OVS_W      = 4;
	// widest word the receiver assembles
	localparam int DEF_WORD_W     = 10;
	// credits available after reset
	localparam int DEF_FIFO_DEPTH = 16;

endpackage

//--- rx_frame_if.sv
//==============================
// strobes, frame state and line sample shared by the receive stages
// no clock inside, every stage brings its own pe_clk
//==============================

`timescale 1ns/1ps

interface rx_frame_if
	import uart_rx_pkg::*;
();

	// bit timer strobes
	logic       sample_pulse;
	logic       sample_done;
	logic       bit_end;
	// frame controller state
	rx_state_e  state;
	logic [3:0] data_idx;
	// checker results
	logic       line_bit;
	logic       noise;

	modport timer (input state, output sample_pulse, sample_done, bit_end);

	modport ctrl (input sample_done, bit_end, line_bit, noise, output state, data_idx);

	modport check (input sample_pulse, sample_done, state, data_idx, output line_bit, noise);

endinterface

//--- rx_bit_timer.sv
//==============================
// oversampling bit timer, one bit is r_clkdiv * r_oversampling cycles
// r_clkdiv must be 1 or more and r_oversampling 3 or more
// counters hold at zero while the frame state is idle
//==============================

`timescale 1ns/1ps

module rx_bit_timer
	import uart_rx_pkg::*;
#(
	parameter int CLKDIV_W = DEF_CLKDIV_W,
	parameter int OVS_W    = DEF_OVS_W
)
(
	input  logic                pe_clk,
	input  logic                pe_rstn,
	input  logic [CLKDIV_W-1:0] r_clkdiv,
	input  logic [OVS_W-1:0]    r_oversampling,
	rx_frame_if.timer           frm
);

	logic [CLKDIV_W-1:0] clkdiv_cnt;
	logic [OVS_W-1:0]    ovs_cnt;
	logic                run;
	logic                div_end;
	logic                ovs_end;
	logic                ovs_mid;
	logic                sample_pulse;
	logic                sample_q;

	// timer runs for any state except idle
	assign run     = (frm.state != RX_IDLE);
	// last divisor cycle of one oversampling point
	assign div_end = (clkdiv_cnt == r_clkdiv - 1'b1);
	// last oversampling point of the bit
	assign ovs_end = (ovs_cnt == r_oversampling - 1'b1);
	// middle point, rounded down
	assign ovs_mid = (ovs_cnt == (r_oversampling >> 1));

	// single cycle at the first divisor cycle of the middle point
	assign sample_pulse = run && ovs_mid && (clkdiv_cnt == '0);

	//==============================
	// counters
	//==============================

	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
		begin
			clkdiv_cnt <= '0;
			ovs_cnt    <= '0;
		end
		else if (!run)
		begin
			clkdiv_cnt <= '0;
			ovs_cnt    <= '0;
		end
		else if (div_end)
		begin
			clkdiv_cnt <= '0;
			// wraps at bit end, next bit starts at point zero
			ovs_cnt    <= ovs_end ? '0 : ovs_cnt + 1'b1;
		end
		else
			clkdiv_cnt <= clkdiv_cnt + 1'b1;
	end

	// line value is stable one cycle after the sample
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			sample_q <= 1'b0;
		else
			sample_q <= sample_pulse;
	end

	assign frm.sample_pulse = sample_pulse;
	assign frm.sample_done  = sample_q;
	assign frm.bit_end      = run && div_end && ovs_end;

endmodule

//--- rx_frame_ctrl.sv
//==============================
// frame state machine, decides every state change
// r_data_bits must lie between 5 and the word width of the checker
// a frame runs to its end once started, rx_enable only arms idle
//==============================

`timescale 1ns/1ps

module rx_frame_ctrl
	import uart_rx_pkg::*;
(
	input  logic       pe_clk,
	input  logic       pe_rstn,
	input  logic       rx_in,
	input  logic       rx_enable,
	input  logic [3:0] r_data_bits,
	input  logic       r_parity_en,
	input  logic       r_two_stop,
	rx_frame_if.ctrl   frm
);

	rx_state_e  state;
	rx_state_e  next_state;
	logic       rx_meta;
	logic       rx_sync;
	logic       rx_prev;
	logic       start_edge;
	logic [3:0] data_idx;
	logic       last_data;
	logic       stop_cnt;
	logic       last_stop;

	//==============================
	// start edge
	//==============================

	// two flop sync, line idles high
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= rx_in;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// falling edge, armed only in idle
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			start_edge <= 1'b0;
		else
			start_edge <= rx_enable && (state == RX_IDLE) && rx_prev && !rx_sync;
	end

	//==============================
	// state machine
	//==============================

	// data ends on the last index, stop on the last stop bit
	assign last_data = (data_idx == r_data_bits - 4'd1);
	assign last_stop = (stop_cnt == r_two_stop);

	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			state <= RX_IDLE;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			RX_IDLE:
				if (start_edge)
					next_state = RX_START;
			// noise drops the frame before the start bit ends
			RX_START:
				if (frm.noise)
					next_state = RX_IDLE;
				else if (frm.bit_end && !frm.line_bit)
					next_state = RX_DATA;
			RX_DATA:
				if (frm.bit_end && last_data)
					next_state = r_parity_en ? RX_PARITY : RX_STOP;
			RX_PARITY:
				if (frm.bit_end)
					next_state = RX_STOP;
			// leave mid stop bit, ready for the next start edge
			RX_STOP:
				if (frm.sample_done && last_stop)
					next_state = RX_IDLE;
			default:
				next_state = RX_IDLE;
		endcase
	end

	//==============================
	// bit counters
	//==============================

	// data bit position, lsb first
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			data_idx <= '0;
		else if (state == RX_START)
			data_idx <= '0;
		else if ((state == RX_DATA) && frm.bit_end && !last_data)
			data_idx <= data_idx + 4'd1;
	end

	// stop bits already finished in this frame
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			stop_cnt <= 1'b0;
		else if (state != RX_STOP)
			stop_cnt <= 1'b0;
		else if (frm.bit_end)
			stop_cnt <= 1'b1;
	end

	assign frm.state    = state;
	assign frm.data_idx = data_idx;

endmodule

//--- rx_frame_check.sv
//==============================
// line sampling, word assembly, parity, stop and noise checks
// flags only, all state changes are made by the frame controller
// unused upper word bits read as zero
//==============================

`timescale 1ns/1ps

module rx_frame_check
	import uart_rx_pkg::*;
#(
	parameter int WORD_W = DEF_WORD_W
)
(
	input  logic              pe_clk,
	input  logic              pe_rstn,
	input  logic              rx_in,
	input  parity_mode_e      r_parity_mode,
	rx_frame_if.check         frm,
	output logic              frame_done,
	output logic [WORD_W-1:0] frame_word,
	output logic              frame_error,
	output logic              parity_error,
	output logic              stop_error
);

	logic              rx_meta;
	logic              rx_sync;
	logic              rx_prev;
	logic              line_rise;
	logic              line_bit;
	logic [WORD_W-1:0] word;
	logic              par_exp;
	logic              err_flag;
	logic              mid_seen;
	logic              noise;
	logic              in_stop_q;

	// two flop sync plus one for the rising edge
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= rx_in;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign line_rise = rx_sync && !rx_prev;

	//==============================
	// sampling and word
	//==============================

	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			line_bit <= 1'b1;
		else if (frm.sample_pulse)
			line_bit <= rx_sync;
	end

	// cleared during the start bit
	always_ff @(posedge pe_clk)
	begin
		if (frm.state == RX_START)
			word <= '0;
		else if ((frm.state == RX_DATA) && frm.sample_pulse && (frm.data_idx < WORD_W))
			word[frm.data_idx] <= rx_sync;
	end

	// follows the word during data, holds through the parity bit
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			par_exp <= 1'b0;
		else if (frm.state == RX_DATA)
		begin
			case (r_parity_mode)
				PAR_EVEN:  par_exp <= ^word;
				PAR_ODD:   par_exp <= ~^word;
				PAR_SPACE: par_exp <= 1'b0;
				default:   par_exp <= 1'b1;
			endcase
		end
	end

	//==============================
	// checks
	//==============================

	assign parity_error = (frm.state == RX_PARITY) && frm.sample_done && (line_bit != par_exp);
	// every stop bit must read high
	assign stop_error   = (frm.state == RX_STOP) && frm.sample_done && !line_bit;

	// sticky until the next start bit
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			err_flag <= 1'b0;
		else if (frm.state == RX_START)
			err_flag <= 1'b0;
		else if (parity_error || stop_error)
			err_flag <= 1'b1;
	end

	// start bit middle reached
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			mid_seen <= 1'b0;
		else if (frm.state != RX_START)
			mid_seen <= 1'b0;
		else if (frm.sample_pulse)
			mid_seen <= 1'b1;
	end

	// early rise, or a glitch too short to see as an edge
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			noise <= 1'b0;
		else
			noise <= (frm.state == RX_START) && !noise &&
				((line_rise && !mid_seen) || (frm.sample_done && line_bit));
	end

	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			in_stop_q <= 1'b0;
		else
			in_stop_q <= (frm.state == RX_STOP);
	end

	// first idle cycle after stop
	assign frame_done  = in_stop_q && (frm.state == RX_IDLE);
	assign frame_word  = word;
	assign frame_error = err_flag;

	assign frm.line_bit = line_bit;
	assign frm.noise    = noise;

endmodule

//--- rx_word_push.sv
//==============================
// error discard, credit count and fifo write
// one credit per fifo entry, returns beyond FIFO_DEPTH are ignored
//==============================

`timescale 1ns/1ps

module rx_word_push
	import uart_rx_pkg::*;
#(
	parameter int WORD_W     = DEF_WORD_W,
	parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
)
(
	input  logic              pe_clk,
	input  logic              pe_rstn,
	input  logic              frame_done,
	input  logic [WORD_W-1:0] frame_word,
	input  logic              frame_error,
	input  logic              r_error_ignore,
	input  logic              credit_return,
	output logic              fifo_we,
	output logic [WORD_W-1:0] fifo_data,
	output logic              overrun
);

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [CNT_W-1:0] credits;
	logic             accept;
	logic             write;

	// good frame, or a bad one the user keeps
	assign accept = frame_done && (!frame_error || r_error_ignore);
	assign write  = accept && (credits != '0);

	// write and return together leave the count alone
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			credits <= CNT_W'(FIFO_DEPTH);
		else if (write && !credit_return)
			credits <= credits - 1'b1;
		else if (!write && credit_return && (credits < CNT_W'(FIFO_DEPTH)))
			credits <= credits + 1'b1;
	end

	// no credit, overrun instead of the write
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
		begin
			fifo_we <= 1'b0;
			overrun <= 1'b0;
		end
		else
		begin
			fifo_we <= write;
			overrun <= accept && !write;
		end
	end

	always_ff @(posedge pe_clk)
	begin
		if (write)
			fifo_data <= frame_word;
	end

endmodule

//--- uart_rx_top.sv
//==============================
// uart receive engine top with plain ports
// latency from start edge to fifo_we depends on the configuration
// status outputs are single cycle pulses
//==============================

`timescale 1ns/1ps

module uart_rx_top
	import uart_rx_pkg::*;
#(
	parameter int CLKDIV_W   = DEF_CLKDIV_W,
	parameter int OVS_W      = DEF_OVS_W,
	parameter int WORD_W     = DEF_WORD_W,
	parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
)
(
	input  logic                pe_clk,
	input  logic                pe_rstn,
	input  logic                uart_rx,
	input  logic                rx_enable,
	input  logic [CLKDIV_W-1:0] r_clkdiv,
	input  logic [OVS_W-1:0]    r_oversampling,
	input  logic [3:0]          r_data_bits,
	input  logic                r_parity_en,
	input  parity_mode_e        r_parity_mode,
	input  logic                r_two_stop,
	input  logic                r_error_ignore,
	input  logic                credit_return,
	output logic                fifo_we,
	output logic [WORD_W-1:0]   fifo_data,
	output logic                int_parity_error,
	output logic                int_stop_error,
	output logic                int_noise,
	output logic                int_stop_detect,
	output logic                int_overrun
);

	logic              frame_done;
	logic [WORD_W-1:0] frame_word;
	logic              frame_error;
	logic              overrun;

	rx_frame_if u_frame_if ();

	// bit timing
	rx_bit_timer #(.CLKDIV_W(CLKDIV_W), .OVS_W(OVS_W)) u_bit_timer
	(
		.pe_clk         (pe_clk),
		.pe_rstn        (pe_rstn),
		.r_clkdiv       (r_clkdiv),
		.r_oversampling (r_oversampling),
		.frm            (u_frame_if.timer)
	);

	// decode
	rx_frame_ctrl u_frame_ctrl
	(
		.pe_clk      (pe_clk),
		.pe_rstn     (pe_rstn),
		.rx_in       (uart_rx),
		.rx_enable   (rx_enable),
		.r_data_bits (r_data_bits),
		.r_parity_en (r_parity_en),
		.r_two_stop  (r_two_stop),
		.frm         (u_frame_if.ctrl)
	);

	// execute
	rx_frame_check #(.WORD_W(WORD_W)) u_frame_check
	(
		.pe_clk        (pe_clk),
		.pe_rstn       (pe_rstn),
		.rx_in         (uart_rx),
		.r_parity_mode (r_parity_mode),
		.frm           (u_frame_if.check),
		.frame_done    (frame_done),
		.frame_word    (frame_word),
		.frame_error   (frame_error),
		.parity_error  (int_parity_error),
		.stop_error    (int_stop_error)
	);

	// result
	rx_word_push #(.WORD_W(WORD_W), .FIFO_DEPTH(FIFO_DEPTH)) u_word_push
	(
		.pe_clk         (pe_clk),
		.pe_rstn        (pe_rstn),
		.frame_done     (frame_done),
		.frame_word     (frame_word),
		.frame_error    (frame_error),
		.r_error_ignore (r_error_ignore),
		.credit_return  (credit_return),
		.fifo_we        (fifo_we),
		.fifo_data      (fifo_data),
		.overrun        (overrun)
	);

	assign int_noise       = u_frame_if.noise;
	// a word written is a stop detect
	assign int_stop_detect = fifo_we;
	assign int_overrun     = overrun;

endmodule

//--- tb_uart_rx.sv
//==============================
// testbench for the uart receive engine
// line driven 1 ns after the rising edge, outputs sampled on the falling edge
// credits are handed back automatically except during the credit test
//==============================

`timescale 1ns/1ps

module tb_uart_rx
	import uart_rx_pkg::*;
();

	localparam int FIFO_DEPTH = 16;
	localparam int WORD_W     = 10;
	localparam int WAIT_LIMIT = 4000;
	// flag counter slots
	localparam int F_PAR = 0;
	localparam int F_STP = 1;
	localparam int F_NSE = 2;
	localparam int F_OVR = 3;
	localparam int F_WR  = 4;

	logic              pe_clk;
	logic              pe_rstn;
	logic              uart_rx;
	logic              rx_enable;
	logic [11:0]       r_clkdiv;
	logic [3:0]        r_oversampling;
	logic [3:0]        r_data_bits;
	logic              r_parity_en;
	parity_mode_e      r_parity_mode;
	logic              r_two_stop;
	logic              r_error_ignore;
	logic              credit_return;
	logic              fifo_we;
	logic [WORD_W-1:0] fifo_data;
	logic              int_parity_error;
	logic              int_stop_error;
	logic              int_noise;
	logic              int_stop_detect;
	logic              int_overrun;

	logic [WORD_W-1:0] exp_q[$];
	int                flag_cnt[5];
	int                errors;
	int                err_start;
	int                test_num;
	int                tests_failed;
	int                credits_owed;
	bit                auto_credit;
	int                seed;
	int                k;
	int                m;

	uart_rx_top #(.WORD_W(WORD_W), .FIFO_DEPTH(FIFO_DEPTH)) UUT
	(
		.pe_clk (pe_clk), .pe_rstn (pe_rstn), .uart_rx (uart_rx), .rx_enable (rx_enable),
		.r_clkdiv (r_clkdiv), .r_oversampling (r_oversampling), .r_data_bits (r_data_bits),
		.r_parity_en (r_parity_en), .r_parity_mode (r_parity_mode), .r_two_stop (r_two_stop),
		.r_error_ignore (r_error_ignore), .credit_return (credit_return),
		.fifo_we (fifo_we), .fifo_data (fifo_data),
		.int_parity_error (int_parity_error), .int_stop_error (int_stop_error),
		.int_noise (int_noise), .int_stop_detect (int_stop_detect), .int_overrun (int_overrun)
	);

	// 100 ns period
	always #50 pe_clk = ~pe_clk;

	//==============================
	// reference and compare
	//==============================

	// {parity bit, word masked to width}
	function automatic logic [WORD_W:0] ref_frame(input logic [WORD_W-1:0] data, input int width,
		input bit par_en, input parity_mode_e mode);
		logic [WORD_W-1:0] word;
		logic              x;
		logic              par;
		word = '0;
		x    = 1'b0;
		for (int i = 0; i < width; i++)
		begin
			word[i] = data[i];
			x       = x ^ data[i];
		end
		case (mode)
			PAR_EVEN:  par = x;
			PAR_ODD:   par = !x;
			PAR_SPACE: par = 1'b0;
			default:   par = 1'b1;
		endcase
		if (!par_en)
			par = 1'b0;
		return {par, word};
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	// every write checked against the expected queue
	always @(negedge pe_clk)
	begin
		if (pe_rstn && fifo_we)
		begin
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("unexpected FIFO write of 0x%0h", fifo_data);
			end
			else
				compare("fifo_data", 32'(fifo_data), 32'(exp_q.pop_front()));
			if (auto_credit)
				credits_owed++;
		end
	end

	// status pulse counters
	always @(negedge pe_clk)
	begin
		if (pe_rstn)
		begin
			if (int_parity_error) flag_cnt[F_PAR]++;
			if (int_stop_error)   flag_cnt[F_STP]++;
			if (int_noise)        flag_cnt[F_NSE]++;
			if (int_overrun)      flag_cnt[F_OVR]++;
			if (int_stop_detect)  flag_cnt[F_WR]++;
		end
	end

	// one return pulse per owed credit
	always @(posedge pe_clk)
	begin
		#1;
		if (credits_owed > 0)
		begin
			credit_return = 1'b1;
			credits_owed--;
		end
		else
			credit_return = 1'b0;
	end

	//==============================
	// line driver
	//==============================

	task automatic drive_bit(input logic value, input int cycles);
		@(posedge pe_clk);
		#1 uart_rx = value;
		repeat (cycles - 1) @(posedge pe_clk);
	endtask

	function automatic int bit_cycles();
		return int'(r_clkdiv) * int'(r_oversampling);
	endfunction

	task automatic line_idle(input int bits);
		drive_bit(1'b1, bits * bit_cycles());
	endtask

	// start, data lsb first, optional parity, stop bits
	task automatic send_frame(input logic [WORD_W-1:0] data, input bit bad_par, input bit bad_stop);
		logic [WORD_W:0] r;
		int              nbits;
		nbits = int'(r_data_bits);
		r = ref_frame(data, nbits, r_parity_en, r_parity_mode);
		drive_bit(1'b0, bit_cycles());
		for (int i = 0; i < nbits; i++)
			drive_bit(data[i], bit_cycles());
		if (r_parity_en)
			drive_bit(r[WORD_W] ^ bad_par, bit_cycles());
		drive_bit(!bad_stop, bit_cycles());
		if (r_two_stop)
			drive_bit(1'b1, bit_cycles());
	endtask

	task automatic send_word(input logic [WORD_W-1:0] data, input bit bad_par, input bit bad_stop,
		input bit expect_write);
		logic [WORD_W:0] r;
		r = ref_frame(data, int'(r_data_bits), r_parity_en, r_parity_mode);
		if (expect_write)
			exp_q.push_back(r[WORD_W-1:0]);
		send_frame(data, bad_par, bad_stop);
	endtask

	task automatic set_format(input int bits, input bit par_en, input parity_mode_e mode,
		input bit two_stop);
		@(posedge pe_clk);
		#1;
		r_data_bits   = 4'(bits);
		r_parity_en   = par_en;
		r_parity_mode = mode;
		r_two_stop    = two_stop;
	endtask

	task automatic set_ignore(input bit value);
		@(posedge pe_clk);
		#1 r_error_ignore = value;
	endtask

	//==============================
	// waits and bookkeeping
	//==============================

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < WAIT_LIMIT)
		begin
			@(posedge pe_clk);
			n++;
		end
		if (exp_q.size() != 0)
		begin
			errors++;
			$display("timeout: %0d expected words were never written", exp_q.size());
		end
	endtask

	task automatic wait_flag(input int idx, input int target, input string what);
		int n;
		n = 0;
		while (flag_cnt[idx] < target && n < WAIT_LIMIT)
		begin
			@(posedge pe_clk);
			n++;
		end
		if (flag_cnt[idx] < target)
		begin
			errors++;
			$display("timeout: %s pulse never seen", what);
		end
	endtask

	task automatic wait_credits();
		int n;
		n = 0;
		while (credits_owed != 0 && n < WAIT_LIMIT)
		begin
			@(posedge pe_clk);
			n++;
		end
		if (credits_owed != 0)
		begin
			errors++;
			$display("timeout: credits were not handed back");
		end
	endtask

	task automatic check_counts(input int par, input int stp, input int nse, input int ovr,
		input int wr);
		compare("int_parity_error count", flag_cnt[F_PAR], par);
		compare("int_stop_error count", flag_cnt[F_STP], stp);
		compare("int_noise count", flag_cnt[F_NSE], nse);
		compare("int_overrun count", flag_cnt[F_OVR], ovr);
		compare("int_stop_detect count", flag_cnt[F_WR], wr);
	endtask

	task automatic begin_test();
		test_num++;
		err_start = errors;
		for (int i = 0; i < 5; i++)
			flag_cnt[i] = 0;
	endtask

	task automatic end_test(input string name);
		if (errors == err_start)
			$display("test %0d %s: ok", test_num, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", test_num, name, errors - err_start);
		end
	endtask

	//==============================
	// tests
	//==============================

	initial
	begin
		pe_clk         = 1'b0;
		pe_rstn        = 1'b0;
		uart_rx        = 1'b1;
		rx_enable      = 1'b0;
		r_clkdiv       = 12'd4;
		r_oversampling = 4'd8;
		r_data_bits    = 4'd8;
		r_parity_en    = 1'b0;
		r_parity_mode  = PAR_EVEN;
		r_two_stop     = 1'b0;
		r_error_ignore = 1'b0;
		credit_return  = 1'b0;
		errors         = 0;
		test_num       = 0;
		tests_failed   = 0;
		credits_owed   = 0;
		auto_credit    = 1'b1;
		for (int i = 0; i < 5; i++)
			flag_cnt[i] = 0;
		seed = $urandom(1659);
		repeat (8) @(posedge pe_clk);
		#1;
		pe_rstn   = 1'b1;
		rx_enable = 1'b1;

		// 8n1, random words, upper bits must be masked
		begin_test();
		set_format(8, 1'b0, PAR_EVEN, 1'b0);
		for (k = 0; k < 8; k++)
			send_word(WORD_W'($urandom), 1'b0, 1'b0, 1'b1);
		wait_drain();
		check_counts(0, 0, 0, 0, 8);
		end_test("8n1 random");

		// good, bad dropped, bad kept, per mode
		begin_test();
		for (m = 0; m < 4; m++)
		begin
			set_format(7, 1'b1, parity_mode_e'(m), 1'b0);
			send_word(WORD_W'($urandom), 1'b0, 1'b0, 1'b1);
			send_word(WORD_W'($urandom), 1'b1, 1'b0, 1'b0);
			set_ignore(1'b1);
			send_word(WORD_W'($urandom), 1'b1, 1'b0, 1'b1);
			set_ignore(1'b0);
		end
		wait_drain();
		wait_flag(F_PAR, 8, "parity error");
		check_counts(8, 0, 0, 0, 8);
		end_test("parity modes");

		// line must go high again after a low stop bit
		begin_test();
		set_format(8, 1'b0, PAR_EVEN, 1'b0);
		send_word(WORD_W'($urandom), 1'b0, 1'b1, 1'b0);
		line_idle(2);
		set_ignore(1'b1);
		send_word(WORD_W'($urandom), 1'b0, 1'b1, 1'b1);
		line_idle(2);
		set_ignore(1'b0);
		send_word(WORD_W'($urandom), 1'b0, 1'b0, 1'b1);
		wait_drain();
		wait_flag(F_STP, 2, "stop error");
		check_counts(0, 2, 0, 0, 2);
		end_test("stop error");

		// glitch of a quarter bit, then a clean frame
		begin_test();
		drive_bit(1'b0, bit_cycles() / 4);
		line_idle(2);
		wait_flag(F_NSE, 1, "noise");
		send_word(WORD_W'($urandom), 1'b0, 1'b0, 1'b1);
		wait_drain();
		check_counts(0, 0, 1, 0, 1);
		end_test("noise");

		// no returns until the burst is over
		begin_test();
		wait_credits();
		auto_credit = 1'b0;
		for (k = 0; k < FIFO_DEPTH + 2; k++)
			send_word(WORD_W'($urandom), 1'b0, 1'b0, k < FIFO_DEPTH);
		wait_drain();
		wait_flag(F_OVR, 2, "overrun");
		check_counts(0, 0, 0, 2, FIFO_DEPTH);
		@(negedge pe_clk);
		credits_owed = credits_owed + FIFO_DEPTH;
		auto_credit  = 1'b1;
		wait_credits();
		send_word(WORD_W'($urandom), 1'b0, 1'b0, 1'b1);
		wait_drain();
		check_counts(0, 0, 0, 2, FIFO_DEPTH + 1);
		end_test("credits");

		// narrowest and widest word, two stop bits
		begin_test();
		set_format(5, 1'b0, PAR_EVEN, 1'b1);
		for (k = 0; k < 4; k++)
			send_word(WORD_W'($urandom), 1'b0, 1'b0, 1'b1);
		set_format(10, 1'b1, PAR_ODD, 1'b1);
		for (k = 0; k < 4; k++)
			send_word(WORD_W'($urandom), 1'b0, 1'b0, 1'b1);
		wait_drain();
		check_counts(0, 0, 0, 0, 8);
		end_test("5 and 10 bits");

		$display("tests run %0d, failed %0d, errors %0d", test_num, tests_failed, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- sources.f
uart_rx_pkg.sv
rx_frame_if.sv
rx_bit_timer.sv
rx_frame_ctrl.sv
rx_frame_check.sv
rx_word_push.sv
uart_rx_top.sv
tb_uart_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the uart receiver testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_uart_rx -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vtb_uart_rx > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
	exit 1
fi

if ! grep -qF "*** TEST PASSED ***" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi

exit 0
